//--- include/mpmem_defines.svh
// multiport memory sizing macros
// word width, address space, lane counts and pipeline latency

`ifndef MPM_DEFINES_SVH
`define MPM_DEFINES_SVH

// storage geometry
`define MPM_WIDTH         16
`define MPM_NUM_ADDR      128
`define MPM_ADDR_BITS     7

// split mode has 5 partitions of 16 rows
`define MPM_LANES         5
`define MPM_ROW_BITS      4

// two read lanes per partition
`define MPM_RD_LANES      10
`define MPM_SHARED_READS  4

// mux, core and demux stages
`define MPM_LATENCY       3

`endif

//--- source/mpmem_pkg.sv
// multiport memory types
// data word, full address, partition row and operating mode

`include "mpmem_defines.svh"

package mpmem_pkg;

  // one stored word
  typedef logic [`MPM_WIDTH-1:0] word_t;

  // address over the whole 128-word store
  typedef logic [`MPM_ADDR_BITS-1:0] addr_t;

  // row inside one 16-row partition
  typedef logic [`MPM_ROW_BITS-1:0] row_t;

  // shared: 4 reads + 1 write over one space
  // split: 5 partitions, each 1 read + 1 read-or-write
  typedef enum logic {
    MODE_SHARED = 1'b0,
    MODE_SPLIT  = 1'b1
  } mode_t;

endpackage

//--- source/mode_port_mux.sv
// input side of the multiport memory
// registers mode and commands, then maps the ports onto core lanes

`timescale 1ns/1ps

`include "mpmem_defines.svh"

module mode_port_mux (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   mode_sel,
  input  logic                                   ready,
  input  logic                                   write,
  input  mpmem_pkg::addr_t                       wr_adr,
  input  mpmem_pkg::word_t                       din,
  input  logic [`MPM_LANES-1:0]                  read,
  input  mpmem_pkg::addr_t [`MPM_LANES-1:0]      rd_adr,
  input  logic [`MPM_LANES-1:0]                  rw_read,
  input  logic [`MPM_LANES-1:0]                  rw_write,
  input  mpmem_pkg::row_t [`MPM_LANES-1:0]       rw_addr,
  input  mpmem_pkg::word_t [`MPM_LANES-1:0]      rw_din,
  output logic [`MPM_LANES-1:0]                  wr_en,
  output mpmem_pkg::addr_t [`MPM_LANES-1:0]      wr_addr,
  output mpmem_pkg::word_t [`MPM_LANES-1:0]      wr_data,
  output logic [`MPM_RD_LANES-1:0]               rd_en,
  output mpmem_pkg::addr_t [`MPM_RD_LANES-1:0]   rd_addr
);
  import mpmem_pkg::*;

  mode_t                     mode_q;
  logic                      write_q;
  logic [`MPM_LANES-1:0]     read_q;
  logic [`MPM_LANES-1:0]     rw_read_q;
  logic [`MPM_LANES-1:0]     rw_write_q;
  addr_t                     wr_adr_q;
  word_t                     din_q;
  addr_t [`MPM_LANES-1:0]    rd_adr_q;
  row_t [`MPM_LANES-1:0]     rw_addr_q;
  word_t [`MPM_LANES-1:0]    rw_din_q;

  // physical address of a row in partition part
  function automatic addr_t part_addr(input int part, input row_t row);
    part_addr = (addr_t'(part) << `MPM_ROW_BITS) | addr_t'(row);
  endfunction

  // strobes are dropped until the clear sweep is done
  always_ff @(posedge clk) begin
    if (rst) begin
      mode_q     <= MODE_SHARED;
      write_q    <= 1'b0;
      read_q     <= '0;
      rw_read_q  <= '0;
      rw_write_q <= '0;
    end else begin
      mode_q     <= mode_t'(mode_sel);
      write_q    <= write & ready;
      read_q     <= read & {`MPM_LANES{ready}};
      rw_read_q  <= rw_read & {`MPM_LANES{ready}};
      rw_write_q <= rw_write & {`MPM_LANES{ready}};
    end
  end

  always_ff @(posedge clk) begin
    wr_adr_q  <= wr_adr;
    din_q     <= din;
    rd_adr_q  <= rd_adr;
    rw_addr_q <= rw_addr;
    rw_din_q  <= rw_din;
  end

  // even read lanes carry read[i], odd lanes carry rw_read[i]
  always_comb begin
    wr_en   = '0;
    wr_addr = '0;
    wr_data = '0;
    rd_en   = '0;
    rd_addr = '0;
    if (mode_q == MODE_SHARED) begin
      wr_en[0]   = write_q;  // single write port on lane 0
      wr_addr[0] = wr_adr_q;
      wr_data[0] = din_q;
      for (int i = 0; i < `MPM_SHARED_READS; i++) begin
        rd_en[2*i]   = read_q[i];
        rd_addr[2*i] = rd_adr_q[i];
      end
    end else begin
      for (int i = 0; i < `MPM_LANES; i++) begin
        wr_en[i]       = rw_write_q[i];
        wr_addr[i]     = part_addr(i, rw_addr_q[i]);
        wr_data[i]     = rw_din_q[i];
        rd_en[2*i]     = read_q[i];
        rd_addr[2*i]   = part_addr(i, rd_adr_q[i][`MPM_ROW_BITS-1:0]);  // low row bits only
        rd_en[2*i+1]   = rw_read_q[i];
        rd_addr[2*i+1] = part_addr(i, rw_addr_q[i]);
      end
    end
  end

endmodule

//--- source/multiport_core.sv
// flop-based storage core with 5 write lanes and 10 registered read lanes
// clears every word after reset and raises ready when the sweep is done

`timescale 1ns/1ps

`include "mpmem_defines.svh"

module multiport_core (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [`MPM_LANES-1:0]                  wr_en,
  input  mpmem_pkg::addr_t [`MPM_LANES-1:0]      wr_addr,
  input  mpmem_pkg::word_t [`MPM_LANES-1:0]      wr_data,
  input  logic [`MPM_RD_LANES-1:0]               rd_en,
  input  mpmem_pkg::addr_t [`MPM_RD_LANES-1:0]   rd_addr,
  output logic                                   ready,
  output logic [`MPM_RD_LANES-1:0]               lane_vld,
  output mpmem_pkg::word_t [`MPM_RD_LANES-1:0]   lane_data
);
  import mpmem_pkg::*;

  localparam addr_t LAST_ADDR = addr_t'(`MPM_NUM_ADDR - 1);

  word_t mem [`MPM_NUM_ADDR];
  addr_t sweep_addr;  // next word to clear

  // clear sweep, one word per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      sweep_addr <= '0;
      ready      <= 1'b0;
    end else if (!ready) begin
      sweep_addr <= sweep_addr + 1'b1;
      if (sweep_addr == LAST_ADDR) begin
        ready <= 1'b1;  // last word cleared on this edge
      end
    end
  end

  // storage update
  // while sweeping no command reaches the core, so the sweep owns the array.
  // on a same-address clash between lanes the higher lane wins
  always_ff @(posedge clk) begin
    if (!ready) begin
      mem[sweep_addr] <= '0;
    end else begin
      for (int i = 0; i < `MPM_LANES; i++) begin
        if (wr_en[i]) begin
          mem[wr_addr[i]] <= wr_data[i];
        end
      end
    end
  end

  // reads sample the array before this edge's writes land
  always_ff @(posedge clk) begin
    for (int j = 0; j < `MPM_RD_LANES; j++) begin
      if (rd_en[j]) begin
        lane_data[j] <= mem[rd_addr[j]];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lane_vld <= '0;
    end else begin
      lane_vld <= rd_en;  // one pulse per accepted read
    end
  end

endmodule

//--- source/result_demux.sv
// output side of the multiport memory
// registers lane results and splits them into rd and rw outputs

`timescale 1ns/1ps

`include "mpmem_defines.svh"

module result_demux (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [`MPM_RD_LANES-1:0]               lane_vld,
  input  mpmem_pkg::word_t [`MPM_RD_LANES-1:0]   lane_data,
  output logic [`MPM_LANES-1:0]                  rd_vld,
  output mpmem_pkg::word_t [`MPM_LANES-1:0]      rd_dout,
  output logic [`MPM_LANES-1:0]                  rw_vld,
  output mpmem_pkg::word_t [`MPM_LANES-1:0]      rw_dout
);
  import mpmem_pkg::*;

  logic [`MPM_RD_LANES-1:0]   vld_q;
  word_t [`MPM_RD_LANES-1:0]  data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= lane_vld;
    end
  end

  // data stays put between valids
  always_ff @(posedge clk) begin
    for (int j = 0; j < `MPM_RD_LANES; j++) begin
      if (lane_vld[j]) begin
        data_q[j] <= lane_data[j];
      end
    end
  end

  // lane 2i is read port i, lane 2i+1 is rw port i in either mode
  for (genvar i = 0; i < `MPM_LANES; i++) begin : g_split
    assign rd_vld[i]  = vld_q[2*i];
    assign rd_dout[i] = data_q[2*i];
    assign rw_vld[i]  = vld_q[2*i+1];
    assign rw_dout[i] = data_q[2*i+1];
  end

endmodule

//--- source/mpmem_top.sv
// multiport memory top level
// input mux, flop storage core and result demux

`timescale 1ns/1ps

`include "mpmem_defines.svh"

module mpmem_top (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   mode_sel,
  input  logic                                   write,
  input  mpmem_pkg::addr_t                       wr_adr,
  input  mpmem_pkg::word_t                       din,
  input  logic [`MPM_LANES-1:0]                  read,
  input  mpmem_pkg::addr_t [`MPM_LANES-1:0]      rd_adr,
  input  logic [`MPM_LANES-1:0]                  rw_read,
  input  logic [`MPM_LANES-1:0]                  rw_write,
  input  mpmem_pkg::row_t [`MPM_LANES-1:0]       rw_addr,
  input  mpmem_pkg::word_t [`MPM_LANES-1:0]      rw_din,
  output logic                                   ready,
  output logic [`MPM_LANES-1:0]                  rd_vld,
  output mpmem_pkg::word_t [`MPM_LANES-1:0]      rd_dout,
  output logic [`MPM_LANES-1:0]                  rw_vld,
  output mpmem_pkg::word_t [`MPM_LANES-1:0]      rw_dout
);
  import mpmem_pkg::*;

  logic [`MPM_LANES-1:0]       wr_en;
  addr_t [`MPM_LANES-1:0]      wr_addr;
  word_t [`MPM_LANES-1:0]      wr_data;
  logic [`MPM_RD_LANES-1:0]    rd_en;
  addr_t [`MPM_RD_LANES-1:0]   rd_addr;
  logic [`MPM_RD_LANES-1:0]    lane_vld;
  word_t [`MPM_RD_LANES-1:0]   lane_data;

  mode_port_mux u_mux (
    .clk      (clk),
    .rst      (rst),
    .mode_sel (mode_sel),
    .ready    (ready),
    .write    (write),
    .wr_adr   (wr_adr),
    .din      (din),
    .read     (read),
    .rd_adr   (rd_adr),
    .rw_read  (rw_read),
    .rw_write (rw_write),
    .rw_addr  (rw_addr),
    .rw_din   (rw_din),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr)
  );

  multiport_core u_core (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .ready     (ready),
    .lane_vld  (lane_vld),
    .lane_data (lane_data)
  );

  result_demux u_demux (
    .clk       (clk),
    .rst       (rst),
    .lane_vld  (lane_vld),
    .lane_data (lane_data),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rw_vld    (rw_vld),
    .rw_dout   (rw_dout)
  );

endmodule

//--- verification/mpmem_checker.sv
// timing assertions for the multiport memory
// bound into the top level, watches ready and the valid pulses

`timescale 1ns/1ps

`include "mpmem_defines.svh"

module mpmem_checker (
  input logic                  clk,
  input logic                  rst,
  input logic                  ready,
  input logic [`MPM_LANES-1:0] read,
  input logic [`MPM_LANES-1:0] rd_vld,
  input logic [`MPM_LANES-1:0] rw_vld
);

  // every rd_vld needs a read taken with ready high, latency edges back
  rd_vld_from_read: assert property (
    @(posedge clk) disable iff (rst)
    (rd_vld & ~$past(read & {`MPM_LANES{ready}}, `MPM_LATENCY)) == '0
  ) else $error("rd_vld high without a matching accepted read");

  // once the sweep is done ready stays up
  ready_stays_high: assert property (
    @(posedge clk) disable iff (rst)
    $past(ready) |-> ready
  ) else $error("ready fell while out of reset");

  quiet_after_reset: assert property (
    @(posedge clk)
    $fell(rst) |-> (!ready && rd_vld == '0 && rw_vld == '0)
  ) else $error("ready or a valid high in the cycle after reset");

endmodule

bind mpmem_top mpmem_checker u_checker (
  .clk    (clk),
  .rst    (rst),
  .ready  (ready),
  .read   (read),
  .rd_vld (rd_vld),
  .rw_vld (rw_vld)
);

//--- verification/mpmem_tb.sv
// testbench for the multiport memory
// table-driven stimulus checked against a reference model of the store

`timescale 1ns/1ps

`include "mpmem_defines.svh"

module mpmem_tb;
  import mpmem_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 3;
  localparam int MARGIN       = 40;  // spare cycles for the watchdog
  localparam int RAND_ENTRIES = 12;
  localparam int SWEEP_BUSY   = 8;  // sweep cycles with reads held on

  typedef logic [`MPM_LANES-1:0] lane_mask_t;

  // everything driven in one cycle
  typedef struct packed {
    mode_t                   mode;
    logic                    write;
    addr_t                   wr_adr;
    word_t                   din;
    lane_mask_t              read;
    addr_t [`MPM_LANES-1:0]  rd_adr;
    lane_mask_t              rw_read;
    lane_mask_t              rw_write;
    row_t [`MPM_LANES-1:0]   rw_addr;
    word_t [`MPM_LANES-1:0]  rw_din;
  } cmd_t;

  typedef struct packed {
    lane_mask_t              rd_vld;
    word_t [`MPM_LANES-1:0]  rd_dout;
    lane_mask_t              rw_vld;
    word_t [`MPM_LANES-1:0]  rw_dout;
  } result_t;

  logic                    clk;
  logic                    rst;
  logic                    mode_sel;
  logic                    write;
  addr_t                   wr_adr;
  word_t                   din;
  lane_mask_t              read;
  addr_t [`MPM_LANES-1:0]  rd_adr;
  lane_mask_t              rw_read;
  lane_mask_t              rw_write;
  row_t [`MPM_LANES-1:0]   rw_addr;
  word_t [`MPM_LANES-1:0]  rw_din;
  logic                    ready;
  lane_mask_t              rd_vld;
  word_t [`MPM_LANES-1:0]  rd_dout;
  lane_mask_t              rw_vld;
  word_t [`MPM_LANES-1:0]  rw_dout;

  cmd_t    stim[$];
  result_t expect_q[$];  // one entry per applied table row
  word_t   ref_mem [`MPM_NUM_ADDR];
  int      table_len = 0;
  int      err_count = 0;
  int      check_count = 0;
  integer  seed = 32'h1437;

  initial clk = 1'b0;
  always #(CLK_PERIOD/2) clk = ~clk;

  mpmem_top DUT (
    .clk      (clk),
    .rst      (rst),
    .mode_sel (mode_sel),
    .write    (write),
    .wr_adr   (wr_adr),
    .din      (din),
    .read     (read),
    .rd_adr   (rd_adr),
    .rw_read  (rw_read),
    .rw_write (rw_write),
    .rw_addr  (rw_addr),
    .rw_din   (rw_din),
    .ready    (ready),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout),
    .rw_vld   (rw_vld),
    .rw_dout  (rw_dout)
  );

  function automatic cmd_t idle_cmd(input mode_t m);
    cmd_t c;
    c = '0;
    c.mode = m;
    return c;
  endfunction

  // flat address of a row within a partition
  function automatic addr_t split_addr(input int part, input row_t row);
    return addr_t'(part * (1 << `MPM_ROW_BITS) + int'(row));
  endfunction

  task automatic build_table();
    cmd_t c;
    // unwritten words read back as zero
    c = idle_cmd(MODE_SHARED);
    c.read = 5'b01111;
    c.rd_adr[0] = 7'd5;
    c.rd_adr[1] = 7'd40;
    c.rd_adr[2] = 7'd77;
    c.rd_adr[3] = 7'd127;
    stim.push_back(c);
    // one write then four parallel reads
    c = idle_cmd(MODE_SHARED);
    c.write = 1'b1;
    c.wr_adr = 7'd10;
    c.din = word_t'($random(seed));
    stim.push_back(c);
    c = idle_cmd(MODE_SHARED);
    c.read = 5'b01111;
    c.rd_adr[0] = 7'd10;
    c.rd_adr[1] = 7'd10;
    c.rd_adr[2] = 7'd11;
    c.rd_adr[3] = 7'd10;
    stim.push_back(c);
    // read[4] and rw ports do nothing in shared mode
    c = idle_cmd(MODE_SHARED);
    c.read = 5'b10000;
    c.rd_adr[4] = 7'd10;
    c.rw_read = '1;
    c.rw_write = '1;
    for (int i = 0; i < `MPM_LANES; i++) begin
      c.rw_addr[i] = 4'd3;
      c.rw_din[i] = word_t'($random(seed));
    end
    stim.push_back(c);
    c = idle_cmd(MODE_SHARED);
    c.read = 5'b01111;
    for (int i = 0; i < `MPM_SHARED_READS; i++) c.rd_adr[i] = split_addr(i, 4'd3);
    stim.push_back(c);
    // split mode writes the same row in every partition
    c = idle_cmd(MODE_SPLIT);
    c.rw_write = '1;
    for (int i = 0; i < `MPM_LANES; i++) begin
      c.rw_addr[i] = 4'd2;
      c.rw_din[i] = word_t'($random(seed));
    end
    stim.push_back(c);
    c = idle_cmd(MODE_SPLIT);
    c.read = '1;
    c.rw_read = '1;
    for (int i = 0; i < `MPM_LANES; i++) begin
      c.rd_adr[i] = 7'h52;  // upper bits ignored in split mode
      c.rw_addr[i] = 4'd2;
    end
    stim.push_back(c);
    // read and write of one word on the same edge
    c = idle_cmd(MODE_SHARED);
    c.write = 1'b1;
    c.wr_adr = 7'd20;
    c.din = word_t'($random(seed));
    c.read = 5'b00001;
    c.rd_adr[0] = 7'd20;
    stim.push_back(c);
    c = idle_cmd(MODE_SHARED);
    c.read = 5'b00001;
    c.rd_adr[0] = 7'd20;
    stim.push_back(c);
    c = idle_cmd(MODE_SPLIT);
    c.rw_write = 5'b00010;
    c.rw_addr[1] = 4'd5;
    c.rw_din[1] = word_t'($random(seed));
    c.read = 5'b00010;
    c.rd_adr[1] = 7'd5;
    stim.push_back(c);
    c = idle_cmd(MODE_SPLIT);
    c.read = 5'b00010;
    c.rd_adr[1] = 7'd5;
    c.rw_read = 5'b00010;
    c.rw_addr[1] = 4'd5;
    stim.push_back(c);
    // partition rows seen as flat addresses and back
    c = idle_cmd(MODE_SHARED);
    c.read = 5'b01111;
    for (int i = 0; i < `MPM_SHARED_READS; i++) c.rd_adr[i] = split_addr(i, 4'd2);
    stim.push_back(c);
    c = idle_cmd(MODE_SHARED);
    c.write = 1'b1;
    c.wr_adr = split_addr(4, 4'd9);
    c.din = word_t'($random(seed));
    stim.push_back(c);
    c = idle_cmd(MODE_SPLIT);
    c.read = 5'b10000;
    c.rd_adr[4] = 7'd9;
    c.rw_read = 5'b01000;
    c.rw_addr[3] = 4'd2;
    stim.push_back(c);
    // random mix where the mode may change every cycle
    for (int n = 0; n < RAND_ENTRIES; n++) begin
      c.mode = (($random(seed) & 1) != 0) ? MODE_SPLIT : MODE_SHARED;
      c.write = ($random(seed) & 1) != 0;
      c.wr_adr = addr_t'($random(seed));
      c.din = word_t'($random(seed));
      c.read = lane_mask_t'($random(seed));
      c.rw_read = lane_mask_t'($random(seed));
      c.rw_write = lane_mask_t'($random(seed));
      for (int i = 0; i < `MPM_LANES; i++) begin
        c.rd_adr[i] = addr_t'($random(seed));
        c.rw_addr[i] = row_t'($random(seed));
        c.rw_din[i] = word_t'($random(seed));
      end
      stim.push_back(c);
    end
  endtask

  task automatic drive_cmd(input cmd_t c);
    mode_sel <= c.mode;
    write    <= c.write;
    wr_adr   <= c.wr_adr;
    din      <= c.din;
    read     <= c.read;
    rd_adr   <= c.rd_adr;
    rw_read  <= c.rw_read;
    rw_write <= c.rw_write;
    rw_addr  <= c.rw_addr;
    rw_din   <= c.rw_din;
  endtask

  // reads see the store before this entry's writes
  task automatic model_step(input cmd_t c);
    result_t r;
    r = '0;
    if (c.mode == MODE_SHARED) begin
      for (int i = 0; i < `MPM_SHARED_READS; i++) begin
        if (c.read[i]) begin
          r.rd_vld[i] = 1'b1;
          r.rd_dout[i] = ref_mem[c.rd_adr[i]];
        end
      end
      if (c.write) ref_mem[c.wr_adr] = c.din;
    end else begin
      for (int i = 0; i < `MPM_LANES; i++) begin
        if (c.read[i]) begin
          r.rd_vld[i] = 1'b1;
          r.rd_dout[i] = ref_mem[split_addr(i, c.rd_adr[i][`MPM_ROW_BITS-1:0])];
        end
        if (c.rw_read[i]) begin
          r.rw_vld[i] = 1'b1;
          r.rw_dout[i] = ref_mem[split_addr(i, c.rw_addr[i])];
        end
      end
      for (int i = 0; i < `MPM_LANES; i++) begin
        if (c.rw_write[i]) ref_mem[split_addr(i, c.rw_addr[i])] = c.rw_din[i];
      end
    end
    expect_q.push_back(r);
  endtask

  task automatic check_outputs(input result_t e);
    check_count++;
    if (rd_vld !== e.rd_vld) begin
      err_count++;
      $display("ERR %0t: rd_vld is %b, expected %b", $time, rd_vld, e.rd_vld);
    end
    if (rw_vld !== e.rw_vld) begin
      err_count++;
      $display("ERR %0t: rw_vld is %b, expected %b", $time, rw_vld, e.rw_vld);
    end
    for (int i = 0; i < `MPM_LANES; i++) begin
      if (e.rd_vld[i] && rd_dout[i] !== e.rd_dout[i]) begin
        err_count++;
        $display("ERR %0t: rd_dout[%0d] is %h, expected %h", $time, i, rd_dout[i], e.rd_dout[i]);
      end
      if (e.rw_vld[i] && rw_dout[i] !== e.rw_dout[i]) begin
        err_count++;
        $display("ERR %0t: rw_dout[%0d] is %h, expected %h", $time, i, rw_dout[i], e.rw_dout[i]);
      end
    end
  endtask

  initial begin
    int      edges;
    cmd_t    idle;
    cmd_t    busy;
    result_t none;
    rst      = 1'b1;
    mode_sel = 1'b0;
    write    = 1'b0;
    wr_adr   = '0;
    din      = '0;
    read     = '0;
    rd_adr   = '0;
    rw_read  = '0;
    rw_write = '0;
    rw_addr  = '0;
    rw_din   = '0;
    for (int a = 0; a < `MPM_NUM_ADDR; a++) ref_mem[a] = '0;  // store after the sweep
    build_table();
    table_len = stim.size();
    none = '0;
    idle = idle_cmd(MODE_SHARED);
    busy = idle_cmd(MODE_SPLIT);
    busy.read = '1;
    busy.rw_read = '1;

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (ready !== 1'b0) begin
      err_count++;
      $display("ERR %0t: ready is high right after reset", $time);
    end
    // reads issued while the sweep runs must be dropped
    edges = 0;
    while (ready !== 1'b1) begin
      @(posedge clk);
      if (edges == 0) begin
        drive_cmd(busy);
      end else if (edges == SWEEP_BUSY) begin
        drive_cmd(idle);
      end
      @(negedge clk);
      edges++;
      if (rd_vld !== '0 || rw_vld !== '0) begin
        err_count++;
        $display("ERR %0t: valid high during the clear sweep", $time);
      end
    end
    if (edges != `MPM_NUM_ADDR) begin
      err_count++;
      $display("ERR %0t: ready rose after %0d cycles, expected %0d", $time, edges,
               `MPM_NUM_ADDR);
    end

    // results of entry n show up MPM_LATENCY edges after it is driven
    for (int n = 0; n < table_len + `MPM_LATENCY; n++) begin
      @(posedge clk);
      if (n < table_len) begin
        drive_cmd(stim[n]);
        model_step(stim[n]);
      end else begin
        drive_cmd(idle);
      end
      @(negedge clk);
      if (n >= `MPM_LATENCY) begin
        check_outputs(expect_q.pop_front());
      end else begin
        check_outputs(none);
      end
    end

    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog sized from reset, sweep and table length
  initial begin
    wait (table_len > 0);
    #((table_len + RESET_CYCLES + `MPM_NUM_ADDR + `MPM_LATENCY + MARGIN) * CLK_PERIOD);
    $display("timeout: the run did not finish in the expected time");
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
source/mpmem_pkg.sv
source/mode_port_mux.sv
source/multiport_core.sv
source/result_demux.sv
source/mpmem_top.sv
verification/mpmem_checker.sv
verification/mpmem_tb.sv

//--- Makefile
# Verilator build and run for the multiport memory testbench

VERILATOR ?= verilator
TOP       := mpmem_tb
FILELIST  := filelist.f
VFLAGS    := --binary --assert -j 0 --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Done: no errors

SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
